// ==== Bender.yml ====
package:
  name: issue_unit

export_include_dirs:
  - include

sources:
  - src/issue_pkg.sv
  - src/issueSelect.sv
  - src/wakeupDelay.sv
  - src/issueLane.sv
  - src/issueQueue.sv
  - src/issueUnit.sv
  - target: test
    files:
      - dv/issueUnit_checker.sv
      - dv/issueUnit_tb.sv

// ==== dv/issueUnit_checker.sv ====
`timescale 1ns/1ps

module issueUnit_checker (
  input logic                 clk,
  input logic                 reset_i,
  input logic                 dispatchReq_i,
  input logic                 dispatchAck_i,
  input issue_pkg::issuePkt_t issue0_i,
  input issue_pkg::issuePkt_t issue1_i
);

  // Assertion failures so far
  int failCount = 0;

  // Ack only answers a request
  ackNeedsReq: assert property (@(posedge clk) disable iff (reset_i)
    $rose(dispatchAck_i) |-> $past(dispatchReq_i))
  else
  begin
    failCount++;
    $error("dispatch ack rose without a request");
  end

  // Ack holds until the source lets go of req
  ackHoldsWithReq: assert property (@(posedge clk) disable iff (reset_i)
    dispatchAck_i && dispatchReq_i |=> dispatchAck_i)
  else
  begin
    failCount++;
    $error("dispatch ack fell while req was high");
  end

  // Issue registers come out of reset empty
  idleAfterReset: assert property (@(posedge clk)
    $fell(reset_i) |-> !issue0_i.valid && !issue1_i.valid)
  else
  begin
    failCount++;
    $error("issue valid set right after reset");
  end

  // Lanes filter by lane, so one id never leaves on both
  distinctIds: assert property (@(posedge clk) disable iff (reset_i)
    issue0_i.valid && issue1_i.valid |-> issue0_i.id != issue1_i.id)
  else
  begin
    failCount++;
    $error("both lanes issued the same id");
  end

endmodule

bind issueUnit issueUnit_checker u_checker (
  .clk           (clk),
  .reset_i       (reset_i),
  .dispatchReq_i (dispatchReq_i),
  .dispatchAck_i (dispatchAck_o),
  .issue0_i      (issue0_o),
  .issue1_i      (issue1_o)
);

// ==== dv/issueUnit_tb.sv ====
`timescale 1ns/1ps

`include "issue_defines.svh"

module issueUnit_tb;

  import issue_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int TEST_COUNT   = 6;
  // Random stream dominates, about five cycles per dispatch
  localparam int CYCLE_BUDGET = 400;
  localparam int STREAM_LEN   = 40;

  // One issue as seen on an output port
  typedef struct packed {
    logic [31:0] cycle;
    logic        port;
    issuePkt_t   pkt;
  } issueRec_t;

  logic         clk = 1'b0;
  logic         reset_i;
  logic         flush_i;
  logic         dispatchReq_i;
  dispatchPkt_t dispatchPkt_i;
  logic         dispatchAck_o;
  physTag_t     extWakeup_i;
  issuePkt_t    issue0_o;
  issuePkt_t    issue1_o;

  // Rising edges since time zero
  int           cycle = 0;
  issueRec_t    issueLog [$];
  logic [31:0]  rngState = 32'd54054;
  dispatchPkt_t streamPkts [STREAM_LEN];

  issueUnit dut0 (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
  end

  // Issue outputs are registered, stable at the falling edge
  // Logged cycle is the issue edge
  always @(negedge clk)
  begin
    if (!reset_i && issue0_o.valid)
    begin
      issueLog.push_back({32'(cycle), 1'b0, issue0_o});
    end
    if (!reset_i && issue1_o.valid)
    begin
      issueLog.push_back({32'(cycle), 1'b1, issue1_o});
    end
  end

  // Watch the bound checker every cycle
  always @(negedge clk)
  begin
    if (dut0.u_checker.failCount != 0)
    begin
      $display("Checker assertion failed at %0t ns", $time);
      $display("TESTS FAILED");
      $fatal(1, "Stopped at first error");
    end
  end

  function automatic logic [31:0] nextRand();
    logic [31:0] x;
    x = rngState;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rngState = x;
    return x;
  endfunction

  // src2 always ready, src1 may wait on a tag
  function automatic dispatchPkt_t makePkt(input int id, input logic lane, input int dest,
                                           input int src1, input logic src1Ready);
    dispatchPkt_t p;
    p.dest.valid = 1'b1;
    p.dest.id    = `PHYS_TAG_W'(dest);
    p.src1       = `PHYS_TAG_W'(src1);
    p.src2       = '0;
    p.src1Ready  = src1Ready;
    p.src2Ready  = 1'b1;
    p.lane       = lane;
    p.id         = `ID_W'(id);
    return p;
  endfunction

  function automatic int countIssues(input int id);
    int n;
    n = 0;
    foreach (issueLog[i])
    begin
      if (issueLog[i].pkt.id == `ID_W'(id))
      begin
        n++;
      end
    end
    return n;
  endfunction

  function automatic int issueIndex(input int id);
    foreach (issueLog[i])
    begin
      if (issueLog[i].pkt.id == `ID_W'(id))
      begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t ns: %s, got %0d, expected %0d", $time, msg, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "Stopped at first error");
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Raise req, optionally with a load broadcast in the same cycle
  task automatic startDispatch(input dispatchPkt_t pkt, input physTag_t ext);
    @(posedge clk);
    dispatchPkt_i <= pkt;
    dispatchReq_i <= 1'b1;
    extWakeup_i   <= ext;
    @(posedge clk);
    extWakeup_i   <= '0;
  endtask

  // Rest of the four-phase handshake
  task automatic finishDispatch();
    do @(negedge clk); while (!dispatchAck_o);
    @(posedge clk);
    dispatchReq_i <= 1'b0;
    do @(negedge clk); while (dispatchAck_o);
  endtask

  task automatic dispatchInstr(input dispatchPkt_t pkt, input physTag_t ext);
    startDispatch(pkt, ext);
    finishDispatch();
  endtask

  // Issued once, on its own lane, with its own destination
  task automatic checkIssued(input dispatchPkt_t pkt);
    int idx;
    idx = issueIndex(pkt.id);
    while (idx < 0)
    begin
      @(negedge clk);
      idx = issueIndex(pkt.id);
    end
    checkEq(countIssues(pkt.id), 1, $sformatf("issue count of id %0d", pkt.id));
    checkEq(issueLog[idx].port, pkt.lane, $sformatf("issue port of id %0d", pkt.id));
    checkEq(issueLog[idx].pkt.lane, pkt.lane, $sformatf("lane field of id %0d", pkt.id));
    checkEq(issueLog[idx].pkt.destId, pkt.dest.id, $sformatf("dest tag of id %0d", pkt.id));
    checkEq(issueLog[idx].pkt.destValid, pkt.dest.valid,
            $sformatf("dest valid of id %0d", pkt.id));
  endtask

  task automatic resetTest();
    @(negedge clk);
    checkEq(dispatchAck_o, 0, "ack after reset");
    checkEq(issue0_o.valid, 0, "lane 0 valid after reset");
    checkEq(issue1_o.valid, 0, "lane 1 valid after reset");
  endtask

  task automatic independentTest();
    dispatchPkt_t pkts [4];
    issueLog.delete();
    for (int i = 0; i < 4; i++)
    begin
      pkts[i] = makePkt(1 + i, 1'(i == 1 || i == 2), 1 + i, 0, 1'b1);
      dispatchInstr(pkts[i], '0);
    end
    idle(6);
    for (int i = 0; i < 4; i++)
    begin
      checkIssued(pkts[i]);
    end
  endtask

  task automatic dependencyTest();
    dispatchPkt_t prod;
    dispatchPkt_t cons;
    int           lat;
    int           gap;
    issueLog.delete();
    for (int l = 0; l < `NUM_LANES; l++)
    begin
      lat  = (l == 0) ? `LANE0_LATENCY : `LANE1_LATENCY;
      prod = makePkt(10 + 2 * l, 1'(l), 8 + l, 0, 1'b1);
      // Consumer sits on the other lane and waits on the producer's tag
      cons = makePkt(11 + 2 * l, 1'(1 - l), 20 + l, 8 + l, 1'b0);
      dispatchInstr(cons, '0);
      dispatchInstr(prod, '0);
      checkIssued(prod);
      checkIssued(cons);
      gap = issueLog[issueIndex(cons.id)].cycle - issueLog[issueIndex(prod.id)].cycle;
      checkEq(gap >= lat + 1, 1, $sformatf("consumer gap %0d on lane %0d", gap, l));
    end
  endtask

  task automatic extWakeupTest();
    dispatchPkt_t waiting [4];
    physTag_t     extTag;
    issueLog.delete();
    extTag.valid = 1'b1;
    extTag.id    = 5'd31;
    for (int i = 0; i < 4; i++)
    begin
      waiting[i] = makePkt(40 + i, 1'(i % 2), 12 + i, 31, 1'b0);
    end
    for (int i = 0; i < 3; i++)
    begin
      dispatchInstr(waiting[i], '0);
    end
    idle(12);
    checkEq(issueLog.size(), 0, "issue before the load tag arrived");
    // Last one rides the bypass in the broadcast cycle
    dispatchInstr(waiting[3], extTag);
    idle(6);
    for (int i = 0; i < 4; i++)
    begin
      checkIssued(waiting[i]);
    end
  endtask

  task automatic fullFlushTest();
    dispatchPkt_t stuck [`ISSUEQ_DEPTH];
    dispatchPkt_t extra;
    physTag_t     deadTag;
    issueLog.delete();
    deadTag.valid = 1'b1;
    deadTag.id    = 5'd30;
    // Tag 30 only shows up after the flush
    for (int i = 0; i < `ISSUEQ_DEPTH; i++)
    begin
      stuck[i] = makePkt(48 + i, 1'(i % 2), 16 + i, 30, 1'b0);
      dispatchInstr(stuck[i], '0);
    end
    extra = makePkt(60, 1'b1, 24, 0, 1'b1);
    startDispatch(extra, '0);
    for (int i = 0; i < 6; i++)
    begin
      @(negedge clk);
      checkEq(dispatchAck_o, 0, "ack while the queue is full");
    end
    @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    finishDispatch();
    // Late broadcast of the stuck tag reaches no flushed entry
    @(posedge clk);
    extWakeup_i <= deadTag;
    @(posedge clk);
    extWakeup_i <= '0;
    idle(8);
    checkIssued(extra);
    for (int i = 0; i < `ISSUEQ_DEPTH; i++)
    begin
      checkEq(countIssues(stuck[i].id), 0, $sformatf("flushed id %0d issued", stuck[i].id));
    end
  endtask

  task automatic randomStreamTest();
    logic [31:0] r;
    issueLog.delete();
    for (int i = 0; i < STREAM_LEN; i++)
    begin
      r = nextRand();
      streamPkts[i] = makePkt(i, r[0], r[12:8], r[20:16], 1'b1);
      streamPkts[i].dest.valid = r[24];
      dispatchInstr(streamPkts[i], '0);
    end
    idle(10);
    for (int i = 0; i < STREAM_LEN; i++)
    begin
      checkIssued(streamPkts[i]);
    end
  endtask

  initial
  begin
    reset_i       = 1'b1;
    flush_i       = 1'b0;
    dispatchReq_i = 1'b0;
    dispatchPkt_i = '0;
    extWakeup_i   = '0;
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;
    resetTest();
    independentTest();
    dependencyTest();
    extWakeupTest();
    fullFlushTest();
    randomStreamTest();
    idle(4);
    if (dut0.u_checker.failCount == 0)
    begin
      $display("TESTS PASSED");
      $finish;
    end
    else
    begin
      $display("Checker assertions failed %0d times", dut0.u_checker.failCount);
      $display("TESTS FAILED");
      $fatal(1, "Checker assertions failed");
    end
  end

  // Hang guard sized by test count
  initial
  begin
    #(TEST_COUNT * CYCLE_BUDGET * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", TEST_COUNT * CYCLE_BUDGET);
    $display("TESTS FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== include/issue_defines.svh ====
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// Issue queue geometry
// Index width must cover the queue depth
`define ISSUEQ_DEPTH 8
`define ISSUEQ_IDX_W 3

// Physical register tag, valid bit not included
`define PHYS_TAG_W 5

// Instruction id carried from dispatch to issue
`define ID_W 6

// Lane 0 is the simple ALU, lane 1 the complex ALU
`define NUM_LANES 2

// Execution latency per lane in cycles
// Sets the wakeup delay of each lane's destination tag
`define LANE0_LATENCY 1
`define LANE1_LATENCY 3

`endif

// ==== src/issueLane.sv ====
`timescale 1ns/1ps

`include "issue_defines.svh"

module issueLane #(
  parameter int LANE_ID = 0,
  parameter int LATENCY = 1
) (
  input  logic                                       clk,
  input  logic                                       reset_i,
  input  logic                                       flush_i,
  input  logic [`ISSUEQ_DEPTH-1:0]                   readyVect_i,
  input  logic [`ISSUEQ_DEPTH-1:0]                   laneVect_i,
  input  issue_pkg::physTag_t [`ISSUEQ_DEPTH-1:0]    destTags_i,
  input  logic [`ISSUEQ_DEPTH-1:0][`ID_W-1:0]        entryIds_i,
  output logic [`ISSUEQ_IDX_W-1:0]                   grantIdx_o,
  output logic                                       grantValid_o,
  output issue_pkg::issuePkt_t                       issue_o,
  output issue_pkg::physTag_t                        wakeupTag_o
);

  import issue_pkg::*;

  // Ready entries that belong to this lane
  logic [`ISSUEQ_DEPTH-1:0] laneReqVect;
  // Destination of the selected entry, headed for the wakeup pipe
  physTag_t                 grantTag;
  // Issue register
  issuePkt_t                issueQ;

  // Lanes filter on their own id, so they never grant the same entry
  always_comb
  begin
    for (int i = 0; i < `ISSUEQ_DEPTH; i++)
    begin
      laneReqVect[i] = readyVect_i[i] && (laneVect_i[i] == 1'(LANE_ID));
    end
  end

  issueSelect u_select (
    .requestVect_i (laneReqVect),
    .grantIdx_o    (grantIdx_o),
    .grantValid_o  (grantValid_o)
  );

  // Only instructions with a real destination wake anybody up
  always_comb
  begin
    grantTag.valid = grantValid_o && destTags_i[grantIdx_o].valid;
    grantTag.id    = destTags_i[grantIdx_o].id;
  end

  // Issue register loads at the same edge the queue frees the entry
  always_ff @(posedge clk)
  begin
    if (reset_i || flush_i)
    begin
      issueQ.valid <= 1'b0;
    end
    else
    begin
      issueQ.valid <= grantValid_o;
      // Payload only moves on a grant
      if (grantValid_o)
      begin
        issueQ.id        <= entryIds_i[grantIdx_o];
        issueQ.destId    <= destTags_i[grantIdx_o].id;
        issueQ.destValid <= destTags_i[grantIdx_o].valid;
        issueQ.lane      <= 1'(LANE_ID);
      end
    end
  end

  assign issue_o = issueQ;

  // Result broadcast LATENCY cycles after the issue edge
  wakeupDelay #(
    .LATENCY (LATENCY)
  ) u_wakeup (
    .clk         (clk),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .grantTag_i  (grantTag),
    .wakeupTag_o (wakeupTag_o)
  );

endmodule

// ==== src/issueQueue.sv ====
`timescale 1ns/1ps

`include "issue_defines.svh"

module issueQueue (
  input  logic                                         clk,
  input  logic                                         reset_i,
  input  logic                                         flush_i,
  input  logic                                         dispatchReq_i,
  input  issue_pkg::dispatchPkt_t                      dispatchPkt_i,
  input  logic [`NUM_LANES-1:0]                        grantValid_i,
  input  logic [`NUM_LANES-1:0][`ISSUEQ_IDX_W-1:0]     grantIdx_i,
  input  issue_pkg::physTag_t [`NUM_LANES:0]           wakeupTags_i,
  output logic                                         dispatchAck_o,
  output logic [`ISSUEQ_DEPTH-1:0]                     readyVect_o,
  output logic [`ISSUEQ_DEPTH-1:0]                     laneVect_o,
  output issue_pkg::physTag_t [`ISSUEQ_DEPTH-1:0]      destTags_o,
  output logic [`ISSUEQ_DEPTH-1:0][`ID_W-1:0]          entryIds_o
);

  import issue_pkg::*;

  iqEntry_t                 entryQ [`ISSUEQ_DEPTH];
  logic                     ackQ;
  // Lowest free slot
  logic [`ISSUEQ_IDX_W-1:0] freeIdx;
  logic                     freeValid;
  logic                     dispatchWrite;
  // Incoming packet after same-cycle wakeup matching
  dispatchPkt_t             bypassPkt;

  // True when any broadcast this cycle carries the source tag
  function automatic logic tagHit(input logic [`PHYS_TAG_W-1:0] src,
                                  input physTag_t [`NUM_LANES:0] tags);
    logic hit;
    hit = 1'b0;
    for (int t = 0; t <= `NUM_LANES; t++)
    begin
      hit |= tags[t].valid && (tags[t].id == src);
    end
    return hit;
  endfunction

  // Free slot search, lowest index first
  always_comb
  begin
    freeIdx   = '0;
    freeValid = 1'b0;
    for (int i = `ISSUEQ_DEPTH-1; i >= 0; i--)
    begin
      if (!entryQ[i].valid)
      begin
        freeIdx   = `ISSUEQ_IDX_W'(i);
        freeValid = 1'b1;
      end
    end
  end

  // New req with ack low, room available, no flush in progress
  // A full queue simply holds ack low
  assign dispatchWrite = dispatchReq_i && !ackQ && freeValid && !flush_i;

  // Bypass so a tag broadcast in the dispatch cycle is not lost
  always_comb
  begin
    bypassPkt           = dispatchPkt_i;
    bypassPkt.src1Ready = dispatchPkt_i.src1Ready || tagHit(dispatchPkt_i.src1, wakeupTags_i);
    bypassPkt.src2Ready = dispatchPkt_i.src2Ready || tagHit(dispatchPkt_i.src2, wakeupTags_i);
  end

  // Four-phase ack
  // Flush leaves an acknowledged handshake alone
  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      ackQ <= 1'b0;
    end
    else if (dispatchWrite)
    begin
      ackQ <= 1'b1;
    end
    else if (ackQ && !dispatchReq_i)
    begin
      ackQ <= 1'b0;
    end
  end

  assign dispatchAck_o = ackQ;

  always_ff @(posedge clk)
  begin
    if (reset_i || flush_i)
    begin
      for (int i = 0; i < `ISSUEQ_DEPTH; i++)
      begin
        entryQ[i].valid <= 1'b0;
      end
    end
    else
    begin
      for (int i = 0; i < `ISSUEQ_DEPTH; i++)
      begin
        // Wakeup of waiting sources
        if (entryQ[i].valid && tagHit(entryQ[i].pkt.src1, wakeupTags_i))
        begin
          entryQ[i].pkt.src1Ready <= 1'b1;
        end
        if (entryQ[i].valid && tagHit(entryQ[i].pkt.src2, wakeupTags_i))
        begin
          entryQ[i].pkt.src2Ready <= 1'b1;
        end
        // Granted entries leave at the issue edge
        for (int l = 0; l < `NUM_LANES; l++)
        begin
          if (grantValid_i[l] && (grantIdx_i[l] == i))
          begin
            entryQ[i].valid <= 1'b0;
          end
        end
        // Free slot cannot be granted, so no conflict with the clear above
        if (dispatchWrite && (freeIdx == i))
        begin
          entryQ[i].valid <= 1'b1;
          entryQ[i].pkt   <= bypassPkt;
        end
      end
    end
  end

  // Per-entry views for the lanes
  always_comb
  begin
    for (int i = 0; i < `ISSUEQ_DEPTH; i++)
    begin
      readyVect_o[i] = entryQ[i].valid && entryQ[i].pkt.src1Ready && entryQ[i].pkt.src2Ready;
      laneVect_o[i]  = entryQ[i].pkt.lane;
      destTags_o[i]  = entryQ[i].pkt.dest;
      entryIds_o[i]  = entryQ[i].pkt.id;
    end
  end

endmodule

// ==== src/issueSelect.sv ====
`timescale 1ns/1ps

`include "issue_defines.svh"

module issueSelect (
  input  logic [`ISSUEQ_DEPTH-1:0] requestVect_i,
  output logic [`ISSUEQ_IDX_W-1:0] grantIdx_o,
  output logic                     grantValid_o
);

  // Fixed priority, lowest index wins
  // Scan downward so the last hit is the lowest requester
  always_comb
  begin
    grantIdx_o   = '0;
    grantValid_o = 1'b0;
    for (int i = `ISSUEQ_DEPTH-1; i >= 0; i--)
    begin
      if (requestVect_i[i])
      begin
        grantIdx_o   = `ISSUEQ_IDX_W'(i);
        grantValid_o = 1'b1;
      end
    end
  end

endmodule

// ==== src/issueUnit.sv ====
`timescale 1ns/1ps

`include "issue_defines.svh"

module issueUnit (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    flush_i,
  input  logic                    dispatchReq_i,
  input  issue_pkg::dispatchPkt_t dispatchPkt_i,
  output logic                    dispatchAck_o,
  input  issue_pkg::physTag_t     extWakeup_i,
  output issue_pkg::issuePkt_t    issue0_o,
  output issue_pkg::issuePkt_t    issue1_o
);

  import issue_pkg::*;

  logic [`ISSUEQ_DEPTH-1:0]                 readyVect;
  logic [`ISSUEQ_DEPTH-1:0]                 laneVect;
  physTag_t [`ISSUEQ_DEPTH-1:0]             destTags;
  logic [`ISSUEQ_DEPTH-1:0][`ID_W-1:0]      entryIds;
  logic                                     grantValid0;
  logic                                     grantValid1;
  logic [`ISSUEQ_IDX_W-1:0]                 grantIdx0;
  logic [`ISSUEQ_IDX_W-1:0]                 grantIdx1;
  physTag_t                                 wakeupTag0;
  physTag_t                                 wakeupTag1;

  issueQueue u_queue (
    .clk           (clk),
    .reset_i       (reset_i),
    .flush_i       (flush_i),
    .dispatchReq_i (dispatchReq_i),
    .dispatchPkt_i (dispatchPkt_i),
    .grantValid_i  ({grantValid1, grantValid0}),
    .grantIdx_i    ({grantIdx1, grantIdx0}),
    // Load unit broadcast sits above the lane tags
    .wakeupTags_i  ({extWakeup_i, wakeupTag1, wakeupTag0}),
    .dispatchAck_o (dispatchAck_o),
    .readyVect_o   (readyVect),
    .laneVect_o    (laneVect),
    .destTags_o    (destTags),
    .entryIds_o    (entryIds)
  );

  // Simple ALU
  issueLane #(
    .LANE_ID (0),
    .LATENCY (`LANE0_LATENCY)
  ) u_lane0 (
    .clk          (clk),
    .reset_i      (reset_i),
    .flush_i      (flush_i),
    .readyVect_i  (readyVect),
    .laneVect_i   (laneVect),
    .destTags_i   (destTags),
    .entryIds_i   (entryIds),
    .grantIdx_o   (grantIdx0),
    .grantValid_o (grantValid0),
    .issue_o      (issue0_o),
    .wakeupTag_o  (wakeupTag0)
  );

  // Complex ALU
  issueLane #(
    .LANE_ID (1),
    .LATENCY (`LANE1_LATENCY)
  ) u_lane1 (
    .clk          (clk),
    .reset_i      (reset_i),
    .flush_i      (flush_i),
    .readyVect_i  (readyVect),
    .laneVect_i   (laneVect),
    .destTags_i   (destTags),
    .entryIds_i   (entryIds),
    .grantIdx_o   (grantIdx1),
    .grantValid_o (grantValid1),
    .issue_o      (issue1_o),
    .wakeupTag_o  (wakeupTag1)
  );

endmodule

// ==== src/issue_pkg.sv ====
`include "issue_defines.svh"

package issue_pkg;

  // Tag on a wakeup bus or a destination register
  typedef struct packed {
    logic                   valid;
    logic [`PHYS_TAG_W-1:0] id;
  } physTag_t;

  // Packet as it arrives on the dispatch port
  typedef struct packed {
    physTag_t               dest;
    logic [`PHYS_TAG_W-1:0] src1;
    logic [`PHYS_TAG_W-1:0] src2;
    logic                   src1Ready;
    logic                   src2Ready;
    // Target lane, 0 simple and 1 complex
    logic                   lane;
    logic [`ID_W-1:0]       id;
  } dispatchPkt_t;

  // One slot of the issue queue
  typedef struct packed {
    logic         valid;
    dispatchPkt_t pkt;
  } iqEntry_t;

  // Instruction leaving a lane
  // Valid for a single cycle, no back-pressure
  typedef struct packed {
    logic                   valid;
    logic [`ID_W-1:0]       id;
    logic [`PHYS_TAG_W-1:0] destId;
    logic                   destValid;
    logic                   lane;
  } issuePkt_t;

endpackage

// ==== src/wakeupDelay.sv ====
`timescale 1ns/1ps

`include "issue_defines.svh"

module wakeupDelay #(
  parameter int LATENCY = 1
) (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                flush_i,
  input  issue_pkg::physTag_t grantTag_i,
  output issue_pkg::physTag_t wakeupTag_o
);

  import issue_pkg::*;

  // One stage per execution cycle
  // Stage 0 loads at the issue edge
  physTag_t stageQ [LATENCY];

  always_ff @(posedge clk)
  begin
    if (reset_i || flush_i)
    begin
      // Only the valid bits matter, ids are masked at the output
      for (int i = 0; i < LATENCY; i++)
      begin
        stageQ[i].valid <= 1'b0;
      end
    end
    else
    begin
      stageQ[0] <= grantTag_i;
      for (int i = 1; i < LATENCY; i++)
      begin
        stageQ[i] <= stageQ[i-1];
      end
    end
  end

  // Broadcast from the last stage
  // Id forced to zero when no result is due
  always_comb
  begin
    wakeupTag_o.valid = stageQ[LATENCY-1].valid;
    wakeupTag_o.id    = stageQ[LATENCY-1].valid ? stageQ[LATENCY-1].id : '0;
  end

endmodule

// ==== vlog.f ====
+incdir+include
src/issue_pkg.sv
src/issueSelect.sv
src/wakeupDelay.sv
src/issueLane.sv
src/issueQueue.sv
src/issueUnit.sv
dv/issueUnit_checker.sv
dv/issueUnit_tb.sv
